// ==== logic/axil_pkg.sv ====
// Fixed 8-bit byte address, 32-bit data; the register window must stay word aligned
`default_nettype none

package axil_pkg;

	////////////////////////////////////////////////////////////
	// Bus widths
	////////////////////////////////////////////////////////////
	localparam int ADDR_WIDTH = 8;
	localparam int DATA_WIDTH = 32;
	localparam int STRB_WIDTH = DATA_WIDTH / 8;
	// Lowest address bit that selects a word
	localparam int ADDRLSB = 2;

	////////////////////////////////////////////////////////////
	// Address map
	////////////////////////////////////////////////////////////
	localparam logic [ADDR_WIDTH-1:0] REGS_BASE = 8'h00;
	localparam int REGS_WORDS = 4;
	// Read-only identifier in the last word
	localparam logic [DATA_WIDTH-1:0] REGS_ID = 32'hA5C1_0001;

	// AXI response codes, EXOKAY never produced
	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_SLVERR = 2'b10,
		RESP_DECERR = 2'b11
	} axil_resp_e;

	// Decoder target
	typedef enum logic {
		SEL_REGS,
		SEL_EMPTY
	} slave_sel_e;

	// Per-channel decoder state
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_ISSUE,
		ST_RESP
	} dec_state_e;

	////////////////////////////////////////////////////////////
	// Channel payloads
	////////////////////////////////////////////////////////////
	typedef struct packed {
		logic [ADDR_WIDTH-1:0] addr;
	} axil_aw_t;

	typedef struct packed {
		logic [DATA_WIDTH-1:0] data;
		logic [STRB_WIDTH-1:0] strb;
	} axil_w_t;

	typedef struct packed {
		axil_resp_e resp;
	} axil_b_t;

	typedef struct packed {
		logic [ADDR_WIDTH-1:0] addr;
	} axil_ar_t;

	typedef struct packed {
		logic [DATA_WIDTH-1:0] data;
		axil_resp_e resp;
	} axil_r_t;

endpackage

`default_nettype wire

// ==== logic/axil_skid.sv ====
// One-entry skid; o_ready is a register, so upstream ready never depends on i_ready in the same cycle
`default_nettype none

module axil_skid #(
	parameter type DT = logic
) (
	input  wire  S_AXI_ACLK,
	input  wire  i_reset,
	// Upstream side
	input  wire  i_valid,
	output logic o_ready,
	input  wire  DT i_data,
	// Downstream side
	output logic o_valid,
	input  wire  i_ready,
	output DT    o_data
);

	// Holding register
	logic r_valid;
	DT    r_data;

	////////////////////////////////////////////////////////////
	// Skid control
	////////////////////////////////////////////////////////////

	// Capture when an item arrives while downstream stalls
	// Release once downstream takes the held item
	always_ff @(posedge S_AXI_ACLK) begin
		if (i_reset) begin
			r_valid <= 1'b0;
		end else if (i_valid && o_ready && !i_ready) begin
			r_valid <= 1'b1;
		end else if (i_ready) begin
			r_valid <= 1'b0;
		end
	end

	// Payload follows input whenever the slot is free
	always_ff @(posedge S_AXI_ACLK) begin
		if (o_ready) begin
			r_data <= i_data;
		end
	end

	// Accept only while the slot is empty
	assign o_ready = !r_valid;

	// Held item goes out first
	assign o_valid = r_valid || i_valid;
	assign o_data  = r_valid ? r_data : i_data;

endmodule

`default_nettype wire

// ==== logic/axil_empty.sv ====
// Answers every request with DECERR and zero data; at most one response held per direction
`default_nettype none

module axil_empty #(
	parameter bit OPT_SKIDBUFFER = 1'b0
) (
	input  wire  S_AXI_ACLK,
	input  wire  i_reset,
	// Write request, no payload needed
	input  wire  i_aw_valid,
	output logic o_aw_ready,
	input  wire  i_w_valid,
	output logic o_w_ready,
	// Write response
	output logic o_b_valid,
	input  wire  i_b_ready,
	output axil_pkg::axil_b_t o_b,
	// Read request and response
	input  wire  i_ar_valid,
	output logic o_ar_ready,
	output logic o_r_valid,
	input  wire  i_r_ready,
	output axil_pkg::axil_r_t o_r
);
	import axil_pkg::*;

	// Request accepted this cycle
	logic write_go;
	logic read_go;

	////////////////////////////////////////////////////////////
	// Request acceptance
	////////////////////////////////////////////////////////////
	if (OPT_SKIDBUFFER) begin : g_skid
		logic aw_skd_valid;
		logic w_skd_valid;
		logic ar_skd_valid;

		// Skids carry only the handshake
		axil_skid aw_skid (
			.S_AXI_ACLK(S_AXI_ACLK), .i_reset(i_reset),
			.i_valid(i_aw_valid), .o_ready(o_aw_ready), .i_data(1'b0),
			.o_valid(aw_skd_valid), .i_ready(write_go), .o_data()
		);

		axil_skid w_skid (
			.S_AXI_ACLK(S_AXI_ACLK), .i_reset(i_reset),
			.i_valid(i_w_valid), .o_ready(o_w_ready), .i_data(1'b0),
			.o_valid(w_skd_valid), .i_ready(write_go), .o_data()
		);

		axil_skid ar_skid (
			.S_AXI_ACLK(S_AXI_ACLK), .i_reset(i_reset),
			.i_valid(i_ar_valid), .o_ready(o_ar_ready), .i_data(1'b0),
			.o_valid(ar_skd_valid), .i_ready(read_go), .o_data()
		);

		// Pop both write skids together once B can take a new response
		assign write_go = aw_skd_valid && w_skd_valid && (!o_b_valid || i_b_ready);
		assign read_go  = ar_skd_valid && (!o_r_valid || i_r_ready);
	end else begin : g_simple
		logic aw_ready_q;

		// One-cycle pulse, AW and W always taken together
		always_ff @(posedge S_AXI_ACLK) begin
			if (i_reset) begin
				aw_ready_q <= 1'b0;
			end else begin
				aw_ready_q <= !aw_ready_q && i_aw_valid && i_w_valid
					&& (!o_b_valid || i_b_ready);
			end
		end

		assign o_aw_ready = aw_ready_q;
		assign o_w_ready  = aw_ready_q;
		assign write_go   = aw_ready_q;

		// Reads accepted whenever R is empty
		assign o_ar_ready = !o_r_valid;
		assign read_go    = i_ar_valid && !o_r_valid;
	end

	////////////////////////////////////////////////////////////
	// Responses
	////////////////////////////////////////////////////////////
	always_ff @(posedge S_AXI_ACLK) begin
		if (i_reset) begin
			o_b_valid <= 1'b0;
		end else if (write_go) begin
			o_b_valid <= 1'b1;
		end else if (i_b_ready) begin
			o_b_valid <= 1'b0;
		end
	end

	always_ff @(posedge S_AXI_ACLK) begin
		if (i_reset) begin
			o_r_valid <= 1'b0;
		end else if (read_go) begin
			o_r_valid <= 1'b1;
		end else if (i_r_ready) begin
			o_r_valid <= 1'b0;
		end
	end

	// Constant answers
	assign o_b = '{resp: RESP_DECERR};
	assign o_r = '{data: '0, resp: RESP_DECERR};

endmodule

`default_nettype wire

// ==== logic/axil_regfile.sv ====
// Four words; upper address bits ignored, so the decoder must filter the window
`default_nettype none

module axil_regfile (
	input  wire  S_AXI_ACLK,
	input  wire  i_reset,
	// Write address and data
	input  wire  i_aw_valid,
	output logic o_aw_ready,
	input  wire  axil_pkg::axil_aw_t i_aw,
	input  wire  i_w_valid,
	output logic o_w_ready,
	input  wire  axil_pkg::axil_w_t i_w,
	// Write response
	output logic o_b_valid,
	input  wire  i_b_ready,
	output axil_pkg::axil_b_t o_b,
	// Read address
	input  wire  i_ar_valid,
	output logic o_ar_ready,
	input  wire  axil_pkg::axil_ar_t i_ar,
	// Read response
	output logic o_r_valid,
	input  wire  i_r_ready,
	output axil_pkg::axil_r_t o_r
);
	import axil_pkg::*;

	// Skidded requests
	logic     aw_skd_valid;
	logic     w_skd_valid;
	logic     ar_skd_valid;
	axil_aw_t aw_skd;
	axil_w_t  w_skd;
	axil_ar_t ar_skd;

	logic write_go;
	logic read_go;
	logic [$clog2(REGS_WORDS)-1:0] w_word;
	logic [$clog2(REGS_WORDS)-1:0] r_word;

	// Writable words, the last one is the identifier
	logic [DATA_WIDTH-1:0] regs [0:REGS_WORDS-2];

	////////////////////////////////////////////////////////////
	// Input skids
	////////////////////////////////////////////////////////////
	axil_skid #(.DT(axil_aw_t)) aw_skid (
		.S_AXI_ACLK(S_AXI_ACLK), .i_reset(i_reset),
		.i_valid(i_aw_valid), .o_ready(o_aw_ready), .i_data(i_aw),
		.o_valid(aw_skd_valid), .i_ready(write_go), .o_data(aw_skd)
	);

	axil_skid #(.DT(axil_w_t)) w_skid (
		.S_AXI_ACLK(S_AXI_ACLK), .i_reset(i_reset),
		.i_valid(i_w_valid), .o_ready(o_w_ready), .i_data(i_w),
		.o_valid(w_skd_valid), .i_ready(write_go), .o_data(w_skd)
	);

	axil_skid #(.DT(axil_ar_t)) ar_skid (
		.S_AXI_ACLK(S_AXI_ACLK), .i_reset(i_reset),
		.i_valid(i_ar_valid), .o_ready(o_ar_ready), .i_data(i_ar),
		.o_valid(ar_skd_valid), .i_ready(read_go), .o_data(ar_skd)
	);

	// Act only when the response slot is free or draining
	assign write_go = aw_skd_valid && w_skd_valid && (!o_b_valid || i_b_ready);
	assign read_go  = ar_skd_valid && (!o_r_valid || i_r_ready);

	assign w_word = aw_skd.addr[ADDRLSB +: $clog2(REGS_WORDS)];
	assign r_word = ar_skd.addr[ADDRLSB +: $clog2(REGS_WORDS)];

	////////////////////////////////////////////////////////////
	// Register writes
	////////////////////////////////////////////////////////////
	always_ff @(posedge S_AXI_ACLK) begin
		if (i_reset) begin
			for (int i = 0; i < REGS_WORDS - 1; i++) begin
				regs[i] <= '0;
			end
		end else if (write_go && (w_word != REGS_WORDS - 1)) begin
			// Byte lanes only where strobed
			for (int b = 0; b < STRB_WIDTH; b++) begin
				if (w_skd.strb[b]) begin
					regs[w_word][b*8 +: 8] <= w_skd.data[b*8 +: 8];
				end
			end
		end
	end

	// Write response
	always_ff @(posedge S_AXI_ACLK) begin
		if (i_reset) begin
			o_b_valid <= 1'b0;
		end else if (write_go) begin
			o_b_valid <= 1'b1;
		end else if (i_b_ready) begin
			o_b_valid <= 1'b0;
		end
	end

	// Identifier word refuses writes
	always_ff @(posedge S_AXI_ACLK) begin
		if (write_go) begin
			o_b.resp <= (w_word == REGS_WORDS - 1) ? RESP_SLVERR : RESP_OKAY;
		end
	end

	////////////////////////////////////////////////////////////
	// Register reads
	////////////////////////////////////////////////////////////
	always_ff @(posedge S_AXI_ACLK) begin
		if (i_reset) begin
			o_r_valid <= 1'b0;
		end else if (read_go) begin
			o_r_valid <= 1'b1;
		end else if (i_r_ready) begin
			o_r_valid <= 1'b0;
		end
	end

	// Read data captured at AR acceptance and held until R completes
	always_ff @(posedge S_AXI_ACLK) begin
		if (read_go) begin
			if (r_word == REGS_WORDS - 1) begin
				o_r.data <= REGS_ID;
			end else begin
				o_r.data <= regs[r_word];
			end
			o_r.resp <= RESP_OKAY;
		end
	end

endmodule

`default_nettype wire

// ==== logic/axil_decoder.sv ====
// One write and one read in flight at most; the select is latched with the request
`default_nettype none

module axil_decoder (
	input  wire  S_AXI_ACLK,
	input  wire  i_reset,
	// Master port
	input  wire  i_aw_valid,
	output logic o_aw_ready,
	input  wire  axil_pkg::axil_aw_t i_aw,
	input  wire  i_w_valid,
	output logic o_w_ready,
	input  wire  axil_pkg::axil_w_t i_w,
	output logic o_b_valid,
	input  wire  i_b_ready,
	output axil_pkg::axil_b_t o_b,
	input  wire  i_ar_valid,
	output logic o_ar_ready,
	input  wire  axil_pkg::axil_ar_t i_ar,
	output logic o_r_valid,
	input  wire  i_r_ready,
	output axil_pkg::axil_r_t o_r,
	// Register file port
	output logic o_regs_aw_valid,
	input  wire  i_regs_aw_ready,
	output axil_pkg::axil_aw_t o_regs_aw,
	output logic o_regs_w_valid,
	input  wire  i_regs_w_ready,
	output axil_pkg::axil_w_t o_regs_w,
	input  wire  i_regs_b_valid,
	output logic o_regs_b_ready,
	input  wire  axil_pkg::axil_b_t i_regs_b,
	output logic o_regs_ar_valid,
	input  wire  i_regs_ar_ready,
	output axil_pkg::axil_ar_t o_regs_ar,
	input  wire  i_regs_r_valid,
	output logic o_regs_r_ready,
	input  wire  axil_pkg::axil_r_t i_regs_r,
	// Error slave port, handshake only on requests
	output logic o_empty_aw_valid,
	input  wire  i_empty_aw_ready,
	output logic o_empty_w_valid,
	input  wire  i_empty_w_ready,
	input  wire  i_empty_b_valid,
	output logic o_empty_b_ready,
	input  wire  axil_pkg::axil_b_t i_empty_b,
	output logic o_empty_ar_valid,
	input  wire  i_empty_ar_ready,
	input  wire  i_empty_r_valid,
	output logic o_empty_r_ready,
	input  wire  axil_pkg::axil_r_t i_empty_r
);
	import axil_pkg::*;

	// Write path
	dec_state_e wr_state;
	slave_sel_e wr_sel;
	axil_aw_t   aw_q;
	axil_w_t    w_q;
	logic       wr_start;
	logic       aw_pend;
	logic       w_pend;
	logic       aw_acc;
	logic       w_acc;
	logic       slv_b_valid;

	// Read path
	dec_state_e rd_state;
	slave_sel_e rd_sel;
	axil_ar_t   ar_q;
	logic       rd_start;
	logic       ar_acc;
	logic       slv_r_valid;

	// Window check on the word offset from the base
	function automatic slave_sel_e sel_of(input logic [ADDR_WIDTH-1:0] addr);
		logic [ADDR_WIDTH-1:0] offset;
		offset = addr - REGS_BASE;
		return ((offset >> ADDRLSB) < ADDR_WIDTH'(REGS_WORDS)) ? SEL_REGS : SEL_EMPTY;
	endfunction

	////////////////////////////////////////////////////////////
	// Write path
	////////////////////////////////////////////////////////////

	// Start only with address and data both present
	assign wr_start = (wr_state == ST_IDLE) && i_aw_valid && i_w_valid;

	always_ff @(posedge S_AXI_ACLK) begin
		if (i_reset) begin
			wr_state   <= ST_IDLE;
			o_aw_ready <= 1'b0;
			aw_pend    <= 1'b0;
			w_pend     <= 1'b0;
		end else begin
			// Ready is a single-cycle pulse after the start
			o_aw_ready <= wr_start;
			case (wr_state)
				ST_IDLE: begin
					if (wr_start) begin
						aw_pend  <= 1'b1;
						w_pend   <= 1'b1;
						wr_state <= ST_ISSUE;
					end
				end
				ST_ISSUE: begin
					// AW and W may be taken on different edges
					if (aw_acc) begin
						aw_pend <= 1'b0;
					end
					if (w_acc) begin
						w_pend <= 1'b0;
					end
					if ((aw_acc || !aw_pend) && (w_acc || !w_pend)) begin
						wr_state <= ST_RESP;
					end
				end
				ST_RESP: begin
					if (o_b_valid && i_b_ready) begin
						wr_state <= ST_IDLE;
					end
				end
				default: wr_state <= ST_IDLE;
			endcase
		end
	end

	// Request and target latched at the start
	always_ff @(posedge S_AXI_ACLK) begin
		if (wr_start) begin
			aw_q   <= i_aw;
			w_q    <= i_w;
			wr_sel <= sel_of(i_aw.addr);
		end
	end

	assign o_w_ready = o_aw_ready;

	// Only the selected slave sees valid
	assign o_regs_aw_valid  = aw_pend && (wr_sel == SEL_REGS);
	assign o_regs_w_valid   = w_pend && (wr_sel == SEL_REGS);
	assign o_empty_aw_valid = aw_pend && (wr_sel == SEL_EMPTY);
	assign o_empty_w_valid  = w_pend && (wr_sel == SEL_EMPTY);
	assign o_regs_aw        = aw_q;
	assign o_regs_w         = w_q;

	assign aw_acc = aw_pend && ((wr_sel == SEL_REGS) ? i_regs_aw_ready : i_empty_aw_ready);
	assign w_acc  = w_pend && ((wr_sel == SEL_REGS) ? i_regs_w_ready : i_empty_w_ready);

	// B passes straight through, ready included
	assign slv_b_valid     = (wr_sel == SEL_REGS) ? i_regs_b_valid : i_empty_b_valid;
	assign o_b_valid       = (wr_state == ST_RESP) && slv_b_valid;
	assign o_b             = (wr_sel == SEL_REGS) ? i_regs_b : i_empty_b;
	assign o_regs_b_ready  = (wr_state == ST_RESP) && (wr_sel == SEL_REGS) && i_b_ready;
	assign o_empty_b_ready = (wr_state == ST_RESP) && (wr_sel == SEL_EMPTY) && i_b_ready;

	////////////////////////////////////////////////////////////
	// Read path
	////////////////////////////////////////////////////////////
	assign rd_start = (rd_state == ST_IDLE) && i_ar_valid;

	always_ff @(posedge S_AXI_ACLK) begin
		if (i_reset) begin
			rd_state   <= ST_IDLE;
			o_ar_ready <= 1'b0;
		end else begin
			o_ar_ready <= rd_start;
			case (rd_state)
				ST_IDLE: begin
					if (rd_start) begin
						rd_state <= ST_ISSUE;
					end
				end
				ST_ISSUE: begin
					if (ar_acc) begin
						rd_state <= ST_RESP;
					end
				end
				ST_RESP: begin
					if (o_r_valid && i_r_ready) begin
						rd_state <= ST_IDLE;
					end
				end
				default: rd_state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge S_AXI_ACLK) begin
		if (rd_start) begin
			ar_q   <= i_ar;
			rd_sel <= sel_of(i_ar.addr);
		end
	end

	assign o_regs_ar_valid  = (rd_state == ST_ISSUE) && (rd_sel == SEL_REGS);
	assign o_empty_ar_valid = (rd_state == ST_ISSUE) && (rd_sel == SEL_EMPTY);
	assign o_regs_ar        = ar_q;
	assign ar_acc = (rd_state == ST_ISSUE)
		&& ((rd_sel == SEL_REGS) ? i_regs_ar_ready : i_empty_ar_ready);

	// R returned unchanged from the selected slave
	assign slv_r_valid     = (rd_sel == SEL_REGS) ? i_regs_r_valid : i_empty_r_valid;
	assign o_r_valid       = (rd_state == ST_RESP) && slv_r_valid;
	assign o_r             = (rd_sel == SEL_REGS) ? i_regs_r : i_empty_r;
	assign o_regs_r_ready  = (rd_state == ST_RESP) && (rd_sel == SEL_REGS) && i_r_ready;
	assign o_empty_r_ready = (rd_state == ST_RESP) && (rd_sel == SEL_EMPTY) && i_r_ready;

endmodule

`default_nettype wire

// ==== logic/axil_fabric_top.sv ====
// Single AXI-lite master; anything outside the register window gets DECERR
`default_nettype none

module axil_fabric_top (
	input  wire  S_AXI_ACLK,
	input  wire  i_reset,
	input  wire  i_aw_valid,
	output logic o_aw_ready,
	input  wire  axil_pkg::axil_aw_t i_aw,
	input  wire  i_w_valid,
	output logic o_w_ready,
	input  wire  axil_pkg::axil_w_t i_w,
	output logic o_b_valid,
	input  wire  i_b_ready,
	output axil_pkg::axil_b_t o_b,
	input  wire  i_ar_valid,
	output logic o_ar_ready,
	input  wire  axil_pkg::axil_ar_t i_ar,
	output logic o_r_valid,
	input  wire  i_r_ready,
	output axil_pkg::axil_r_t o_r
);
	import axil_pkg::*;

	////////////////////////////////////////////////////////////
	// Decoder to register file
	////////////////////////////////////////////////////////////
	logic     regs_aw_valid, regs_aw_ready;
	logic     regs_w_valid, regs_w_ready;
	logic     regs_b_valid, regs_b_ready;
	logic     regs_ar_valid, regs_ar_ready;
	logic     regs_r_valid, regs_r_ready;
	axil_aw_t regs_aw;
	axil_w_t  regs_w;
	axil_b_t  regs_b;
	axil_ar_t regs_ar;
	axil_r_t  regs_r;

	// Decoder to error slave
	logic    empty_aw_valid, empty_aw_ready;
	logic    empty_w_valid, empty_w_ready;
	logic    empty_b_valid, empty_b_ready;
	logic    empty_ar_valid, empty_ar_ready;
	logic    empty_r_valid, empty_r_ready;
	axil_b_t empty_b;
	axil_r_t empty_r;

	axil_decoder u_decoder (
		.S_AXI_ACLK(S_AXI_ACLK), .i_reset(i_reset),
		.i_aw_valid(i_aw_valid), .o_aw_ready(o_aw_ready), .i_aw(i_aw),
		.i_w_valid(i_w_valid), .o_w_ready(o_w_ready), .i_w(i_w),
		.o_b_valid(o_b_valid), .i_b_ready(i_b_ready), .o_b(o_b),
		.i_ar_valid(i_ar_valid), .o_ar_ready(o_ar_ready), .i_ar(i_ar),
		.o_r_valid(o_r_valid), .i_r_ready(i_r_ready), .o_r(o_r),
		.o_regs_aw_valid(regs_aw_valid), .i_regs_aw_ready(regs_aw_ready),
		.o_regs_aw(regs_aw),
		.o_regs_w_valid(regs_w_valid), .i_regs_w_ready(regs_w_ready),
		.o_regs_w(regs_w),
		.i_regs_b_valid(regs_b_valid), .o_regs_b_ready(regs_b_ready),
		.i_regs_b(regs_b),
		.o_regs_ar_valid(regs_ar_valid), .i_regs_ar_ready(regs_ar_ready),
		.o_regs_ar(regs_ar),
		.i_regs_r_valid(regs_r_valid), .o_regs_r_ready(regs_r_ready),
		.i_regs_r(regs_r),
		.o_empty_aw_valid(empty_aw_valid), .i_empty_aw_ready(empty_aw_ready),
		.o_empty_w_valid(empty_w_valid), .i_empty_w_ready(empty_w_ready),
		.i_empty_b_valid(empty_b_valid), .o_empty_b_ready(empty_b_ready),
		.i_empty_b(empty_b),
		.o_empty_ar_valid(empty_ar_valid), .i_empty_ar_ready(empty_ar_ready),
		.i_empty_r_valid(empty_r_valid), .o_empty_r_ready(empty_r_ready),
		.i_empty_r(empty_r)
	);

	axil_regfile u_regfile (
		.S_AXI_ACLK(S_AXI_ACLK), .i_reset(i_reset),
		.i_aw_valid(regs_aw_valid), .o_aw_ready(regs_aw_ready), .i_aw(regs_aw),
		.i_w_valid(regs_w_valid), .o_w_ready(regs_w_ready), .i_w(regs_w),
		.o_b_valid(regs_b_valid), .i_b_ready(regs_b_ready), .o_b(regs_b),
		.i_ar_valid(regs_ar_valid), .o_ar_ready(regs_ar_ready), .i_ar(regs_ar),
		.o_r_valid(regs_r_valid), .i_r_ready(regs_r_ready), .o_r(regs_r)
	);

	// Error slave with skids on its request channels
	axil_empty #(.OPT_SKIDBUFFER(1'b1)) u_empty (
		.S_AXI_ACLK(S_AXI_ACLK), .i_reset(i_reset),
		.i_aw_valid(empty_aw_valid), .o_aw_ready(empty_aw_ready),
		.i_w_valid(empty_w_valid), .o_w_ready(empty_w_ready),
		.o_b_valid(empty_b_valid), .i_b_ready(empty_b_ready), .o_b(empty_b),
		.i_ar_valid(empty_ar_valid), .o_ar_ready(empty_ar_ready),
		.o_r_valid(empty_r_valid), .i_r_ready(empty_r_ready), .o_r(empty_r)
	);

endmodule

`default_nettype wire

// ==== sim/axil_fabric_tb.sv ====
// Reads sim/axil_fabric_input.txt from the project root; one transaction at a time
`default_nettype none

module axil_fabric_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import axil_pkg::*;

	logic     S_AXI_ACLK;
	logic     i_reset;
	logic     i_aw_valid, o_aw_ready;
	logic     i_w_valid, o_w_ready;
	logic     o_b_valid, i_b_ready;
	logic     i_ar_valid, o_ar_ready;
	logic     o_r_valid, i_r_ready;
	axil_aw_t i_aw;
	axil_w_t  i_w;
	axil_b_t  o_b;
	axil_ar_t i_ar;
	axil_r_t  o_r;

	axil_fabric_top dut (
		.S_AXI_ACLK(S_AXI_ACLK), .i_reset(i_reset),
		.i_aw_valid(i_aw_valid), .o_aw_ready(o_aw_ready), .i_aw(i_aw),
		.i_w_valid(i_w_valid), .o_w_ready(o_w_ready), .i_w(i_w),
		.o_b_valid(o_b_valid), .i_b_ready(i_b_ready), .o_b(o_b),
		.i_ar_valid(i_ar_valid), .o_ar_ready(o_ar_ready), .i_ar(i_ar),
		.o_r_valid(o_r_valid), .i_r_ready(i_r_ready), .o_r(o_r)
	);

	// 8 ns clock
	initial begin
		S_AXI_ACLK = 1'b0;
		forever #4 S_AXI_ACLK = ~S_AXI_ACLK;
	end

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////

	// Print the reason and end the run as failed
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Checks failed");
		$fatal(1, "Simulation stopped on first error");
	endtask

	task automatic check_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (actual !== expected) begin
			abort_run($sformatf("Mismatch %s: expected 0x%0h, actual 0x%0h",
				name, expected, actual));
		end
	endtask

	// Handshake code 0 is AW ready, 1 B valid, 2 AR ready, 3 R valid
	function automatic logic handshake_level(input int which);
		case (which)
			0: return o_aw_ready;
			1: return o_b_valid;
			2: return o_ar_ready;
			default: return o_r_valid;
		endcase
	endfunction

	// Response payload with B widened to the R layout
	function automatic logic [33:0] response_word(input bit is_read);
		return is_read ? 34'(o_r) : 34'({32'h0, o_b});
	endfunction

	// Sampled on the falling edge, so the next rising edge is the transfer
	task automatic wait_high(input int which, input string what);
		int cycles;
		cycles = 0;
		@(negedge S_AXI_ACLK);
		while (!handshake_level(which)) begin
			cycles++;
			if (cycles >= 100) begin
				abort_run($sformatf("Timeout after 100 cycles waiting for %s", what));
			end
			@(negedge S_AXI_ACLK);
		end
	endtask

	task automatic drive_ready(input bit is_read, input logic level);
		if (is_read) begin
			i_r_ready = level;
		end else begin
			i_b_ready = level;
		end
	endtask

	// Back-pressure followed by one response transfer
	task automatic take_response(input bit is_read, input string name,
		output logic [33:0] word);
		int          hold;
		int          vsel;
		bit          seen;
		logic [33:0] held;
		vsel = is_read ? 3 : 1;
		hold = int'($urandom % 32'd6);
		seen = 1'b0;
		held = '0;
		// Ready low; a response seen meanwhile must not move
		for (int i = 0; i < hold; i++) begin
			@(negedge S_AXI_ACLK);
			if (seen) begin
				check_value({name, " valid held"}, 64'd1, 64'(handshake_level(vsel)));
				check_value({name, " payload held"}, 64'(held), 64'(response_word(is_read)));
			end else if (handshake_level(vsel)) begin
				seen = 1'b1;
				held = response_word(is_read);
			end
		end
		if (hold > 0) begin
			@(posedge S_AXI_ACLK);
			#1;
		end
		drive_ready(is_read, 1'b1);
		wait_high(vsel, is_read ? "R valid" : "B valid");
		word = response_word(is_read);
		if (seen) begin
			check_value({name, " payload at transfer"}, 64'(held), 64'(word));
		end
		@(posedge S_AXI_ACLK);
		#1;
		drive_ready(is_read, 1'b0);
		// No second response for the same request
		@(negedge S_AXI_ACLK);
		check_value({name, " single response"}, 64'd0, 64'(handshake_level(vsel)));
	endtask

	task automatic write_word(input string name, input logic [7:0] addr,
		input logic [31:0] data, input logic [3:0] strb, output logic [1:0] resp);
		logic [33:0] word;
		@(posedge S_AXI_ACLK);
		#1;
		i_aw.addr  = addr;
		i_w.data   = data;
		i_w.strb   = strb;
		i_aw_valid = 1'b1;
		i_w_valid  = 1'b1;
		wait_high(0, "AW ready");
		check_value({name, " W ready with AW"}, 64'd1, 64'(o_w_ready));
		@(posedge S_AXI_ACLK);
		#1;
		i_aw_valid = 1'b0;
		i_w_valid  = 1'b0;
		take_response(1'b0, name, word);
		resp = word[1:0];
	endtask

	task automatic read_word(input string name, input logic [7:0] addr,
		output logic [31:0] data, output logic [1:0] resp);
		logic [33:0] word;
		@(posedge S_AXI_ACLK);
		#1;
		i_ar.addr  = addr;
		i_ar_valid = 1'b1;
		wait_high(2, "AR ready");
		@(posedge S_AXI_ACLK);
		#1;
		i_ar_valid = 1'b0;
		take_response(1'b1, name, word);
		data = word[33:2];
		resp = word[1:0];
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////
	initial begin
		int          fd;
		int          fields;
		int          count;
		string       line;
		string       name;
		string       op;
		logic [7:0]  addr;
		logic [31:0] data;
		logic [3:0]  strb;
		logic [1:0]  exp_resp;
		logic [31:0] exp_data;
		logic [1:0]  resp;
		logic [31:0] rdata;
		void'($urandom(71));
		i_reset    = 1'b1;
		i_aw_valid = 1'b0;
		i_w_valid  = 1'b0;
		i_ar_valid = 1'b0;
		i_b_ready  = 1'b0;
		i_r_ready  = 1'b0;
		i_aw       = '0;
		i_w        = '0;
		i_ar       = '0;
		repeat (10) @(posedge S_AXI_ACLK);
		#1;
		i_reset = 1'b0;
		// Idle bus straight after reset
		@(negedge S_AXI_ACLK);
		check_value("reset B valid", 64'd0, 64'(o_b_valid));
		check_value("reset R valid", 64'd0, 64'(o_r_valid));
		check_value("reset AW ready", 64'd0, 64'(o_aw_ready));
		check_value("reset W ready", 64'd0, 64'(o_w_ready));
		check_value("reset AR ready", 64'd0, 64'(o_ar_ready));
		fd = $fopen("sim/axil_fabric_input.txt", "r");
		if (fd == 0) begin
			abort_run("Could not open the stimulus file sim/axil_fabric_input.txt");
		end
		count = 0;
		while ($fgets(line, fd) != 0) begin
			// Skip comments and blank lines
			if (line.len() < 2 || line.getc(0) == "#") begin
				continue;
			end
			fields = $sscanf(line, "%s %s %h %h %h %h %h",
				name, op, addr, data, strb, exp_resp, exp_data);
			if (fields != 7) begin
				abort_run({"Stimulus line could not be parsed: ", line});
			end
			if (op == "W") begin
				write_word(name, addr, data, strb, resp);
				check_value({name, " B resp"}, 64'(exp_resp), 64'(resp));
			end else begin
				read_word(name, addr, rdata, resp);
				check_value({name, " R resp"}, 64'(exp_resp), 64'(resp));
				check_value({name, " R data"}, 64'(exp_data), 64'(rdata));
			end
			count++;
		end
		$fclose(fd);
		if (count == 0) begin
			abort_run("The stimulus file holds no transactions");
		end else begin
			$display("All checks passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== axil_fabric.f ====
logic/axil_pkg.sv
logic/axil_skid.sv
logic/axil_empty.sv
logic/axil_regfile.sv
logic/axil_decoder.sv
logic/axil_fabric_top.sv
sim/axil_fabric_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the AXI-lite fabric testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module axil_fabric_tb \
	-f axil_fabric.f -o axil_fabric_sim > build.log 2>&1 \
	&& ./obj_dir/axil_fabric_sim > sim.log 2>&1 \
	|| echo "Build or simulation returned an error, see build.log and sim.log"
cat build.log sim.log 2> /dev/null
grep -q "All checks passed" sim.log 2> /dev/null \
	&& echo "Result: PASS" \
	|| { echo "Result: FAIL"; exit 1; }

// ==== sim/axil_fabric_input.txt ====
# name op addr(hex) data(hex) strb(hex) resp(0 OKAY, 2 SLVERR, 3 DECERR) rdata(hex)
# Writes ignore rdata; reads ignore data and strb
rst_rd0 R 00 00000000 0 0 00000000
rst_rd1 R 04 00000000 0 0 00000000
rst_rd2 R 08 00000000 0 0 00000000
wr0 W 00 11223344 f 0 00000000
wr1 W 04 cafef00d f 0 00000000
wr2 W 08 0badbeef f 0 00000000
rd0 R 00 00000000 0 0 11223344
rd1 R 04 00000000 0 0 cafef00d
rd2 R 08 00000000 0 0 0badbeef
part_wr1 W 04 a1b2c3d4 5 0 00000000
part_rd1 R 04 00000000 0 0 cab2f0d4
part_wr2 W 08 77000000 8 0 00000000
part_rd2 R 08 00000000 0 0 77adbeef
id_rd R 0c 00000000 0 0 a5c10001
id_wr W 0c ffffffff f 2 00000000
id_rerd R 0c 00000000 0 0 a5c10001
oob_wr W 10 12345678 f 3 00000000
oob_rd R 10 00000000 0 3 00000000
oob_wr_hi W 80 deadbeef f 3 00000000
oob_rd_hi R fc 00000000 0 3 00000000
rd0_again R 00 00000000 0 0 11223344
